/* Bender.yml */
package:
  name: wb_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cpu_pkg.sv
      - src/trap_csr_if.sv
      - src/csr_file.sv
      - src/trap_unit.sv
      - src/wb_commit.sv
      - src/wb_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/wb_props.sv
      - sim/wb_tb.sv

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path width
`define XLEN			32

// platform interrupt lines, mapped to mip[31:16]
`define IRQ_EXT_LINES	16

// mstatus fields
`define MSTATUS_MIE_BIT		3
`define MSTATUS_MPIE_BIT	7

// misa extension bits
`define MISA_M_BIT		12
`define MISA_F_BIT		5

// RV32 (MXL=1) with I, M and F
`define MISA_RESET		32'h4000_1120

// only the M and F bits of misa can be changed
`define MISA_WMASK		((32'h1 << `MISA_M_BIT) | (32'h1 << `MISA_F_BIT))

// direct mode trap base
`define MTVEC_RESET		32'h0000_0100

// software, timer, controller and platform lines
`define MIE_MASK		32'hFFFF_0888

`endif

/* sim.f */
+incdir+include
src/cpu_pkg.sv
src/trap_csr_if.sv
src/csr_file.sv
src/trap_unit.sv
src/wb_commit.sv
src/wb_stage.sv
sim/wb_props.sv
sim/wb_tb.sv

/* sim/wb_props.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_props (
	input	wire logic	clk,
	input	wire logic	reset,
	input	wire logic	valid_in,
	input	wire logic	ready_in,
	input	wire logic	ready_out,
	input	wire logic	valid_out,
	input	wire logic	rd_wena_WB,
	input	wire logic	trap_taken_csr
);

	int unsigned fail_count = 0;	// read by the testbench at the end

	valid_in_reset: assert property (@(posedge clk) reset |-> !valid_out)
		else begin
			fail_count++;
			$error("valid_out high during reset");
		end

	// trapping instruction writes no register
	no_write_on_trap: assert property (@(posedge clk) disable iff (reset)
			!(rd_wena_WB && trap_taken_csr))
		else begin
			fail_count++;
			$error("register write together with a trap");
		end

	ready_pass: assert property (@(posedge clk) disable iff (reset) ready_out == ready_in)
		else begin
			fail_count++;
			$error("ready_out differs from ready_in");
		end

	trap_needs_valid: assert property (@(posedge clk) disable iff (reset)
			trap_taken_csr |-> valid_in)
		else begin
			fail_count++;
			$error("trap taken without a valid instruction");
		end

endmodule

bind wb_stage wb_props props_inst (.*);

`default_nettype wire

/* sim/wb_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module wb_tb;

	import cpu_pkg::*;

	localparam int TIMEOUT = 20;
	localparam word_t MISA_MASK = (32'h1 << `MISA_M_BIT) | (32'h1 << `MISA_F_BIT);

	logic						clk;
	logic						reset;
	logic						valid_in;
	logic						ready_out;
	logic						valid_out;
	logic						ready_in;
	logic [`IRQ_EXT_LINES-1:0]	irq_ext;
	logic						irq_int_controller;
	logic						irq_timer;
	logic						irq_software;
	logic						M_ena_csr;
	logic						F_ena_csr;
	frm_t						fpu_rm_csr;
	logic						exc_taken_csr;
	logic						trap_taken_csr;
	word_t						trap_addr_csr;
	word_t						trap_raddr_csr;
	word_t						PC_MEM;
	logic						rd_wena_MEM;
	reg_addr_t					rd_addr_MEM;
	word_t						rd_data_MEM;
	csr_addr_t					csr_addr_MEM;
	logic						csr_rena_MEM;
	logic						csr_wena_MEM;
	word_t						csr_wdata_MEM;
	wb_src_e					wb_src_MEM;
	csr_op_e					csr_op_MEM;
	fflags_t					fpu_flags_MEM;
	logic						trap_ret_MEM;
	logic						exc_pend_MEM;
	cause_t						exc_cause_MEM;
	logic						rd_wena_WB;
	reg_addr_t					rd_addr_WB;
	word_t						rd_data_WB;

	// next instruction, copied onto the bus by issue
	word_t						ins_pc;
	logic						ins_rd_wena;
	reg_addr_t					ins_rd_addr;
	word_t						ins_rd_data;
	csr_addr_t					ins_csr_addr;
	logic						ins_csr_wena;
	word_t						ins_csr_wdata;
	csr_op_e					ins_csr_op;
	wb_src_e					ins_wb_src;
	fflags_t					ins_flags;
	logic						ins_ret;
	logic						ins_exc;
	cause_t						ins_cause;
	logic [`IRQ_EXT_LINES-1:0]	ins_irq_ext = '0;
	logic						ins_irq_ctrl = 1'b0;
	logic						ins_irq_timer = 1'b0;
	logic						ins_irq_sw = 1'b0;

	// reference CSR state
	word_t		m_mstatus = '0;
	word_t		m_misa = `MISA_RESET;
	word_t		m_mie = '0;
	word_t		m_mtvec = `MTVEC_RESET;
	word_t		m_mepc = '0;
	word_t		m_mcause = '0;
	fflags_t	m_fflags = '0;
	frm_t		m_frm = '0;

	word_t		rng = 32'd96;
	csr_addr_t	csr_list [10] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MEPC,
			CSR_MCAUSE, CSR_MIP, CSR_FFLAGS, CSR_FRM, CSR_FCSR};

	wb_stage wb_stage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t xorshift32(input word_t x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t rand_word();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic word_t model_mip();
		word_t m;
		m = '0;
		m[CAUSE_IRQ_SOFTWARE] = ins_irq_sw;
		m[CAUSE_IRQ_TIMER] = ins_irq_timer;
		m[CAUSE_IRQ_CTRL] = ins_irq_ctrl;
		m[CAUSE_IRQ_EXT_BASE +: `IRQ_EXT_LINES] = ins_irq_ext;
		return m;
	endfunction

	function automatic word_t model_read(input csr_addr_t addr);
		case (addr)
			CSR_MSTATUS:	return m_mstatus;
			CSR_MISA:		return m_misa;
			CSR_MIE:		return m_mie;
			CSR_MTVEC:		return m_mtvec;
			CSR_MEPC:		return m_mepc;
			CSR_MCAUSE:		return m_mcause;
			CSR_MIP:		return model_mip();
			CSR_FFLAGS:		return word_t'(m_fflags);
			CSR_FRM:		return word_t'(m_frm);
			CSR_FCSR:		return word_t'({m_frm, m_fflags});
			default:		return '0;
		endcase
	endfunction

	// platform lines first, lowest index wins
	function automatic cause_t expected_irq_cause(input word_t pend);
		for (int i = 0; i < `IRQ_EXT_LINES; i++)
			if (pend[CAUSE_IRQ_EXT_BASE + i])
				return {1'b1, 31'(CAUSE_IRQ_EXT_BASE + i)};
		if (pend[CAUSE_IRQ_CTRL])
			return {1'b1, 31'(CAUSE_IRQ_CTRL)};
		if (pend[CAUSE_IRQ_SOFTWARE])
			return {1'b1, 31'(CAUSE_IRQ_SOFTWARE)};
		return {1'b1, 31'(CAUSE_IRQ_TIMER)};
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic wait_valid_out(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (valid_out !== level && n < TIMEOUT);
		if (valid_out !== level) begin
			$display("valid_out did not reach %0b within %0d cycles", level, TIMEOUT);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	endtask

	task automatic clear_fields();
		ins_pc = rand_word() & ~32'h3;
		ins_rd_wena = 1'b0;
		ins_rd_addr = '0;
		ins_rd_data = '0;
		ins_csr_addr = CSR_MSTATUS;
		ins_csr_wena = 1'b0;
		ins_csr_wdata = '0;
		ins_csr_op = CSR_NONE;
		ins_wb_src = SEL_RES;
		ins_flags = '0;
		ins_ret = 1'b0;
		ins_exc = 1'b0;
		ins_cause = '0;
	endtask

	// one accepted instruction, checked in its accept cycle
	task automatic issue(input logic stall_after = 1'b0);
		word_t pend;
		logic irq;
		logic trap;
		word_t old;
		word_t nv;
		@(posedge clk);
		valid_in <= 1'b1;
		ready_in <= 1'b1;
		PC_MEM <= ins_pc;
		rd_wena_MEM <= ins_rd_wena;
		rd_addr_MEM <= ins_rd_addr;
		rd_data_MEM <= ins_rd_data;
		csr_addr_MEM <= ins_csr_addr;
		csr_rena_MEM <= (ins_wb_src == SEL_CSR);
		csr_wena_MEM <= ins_csr_wena;
		csr_wdata_MEM <= ins_csr_wdata;
		csr_op_MEM <= ins_csr_op;
		wb_src_MEM <= ins_wb_src;
		fpu_flags_MEM <= ins_flags;
		trap_ret_MEM <= ins_ret;
		exc_pend_MEM <= ins_exc;
		exc_cause_MEM <= ins_cause;
		irq_ext <= ins_irq_ext;
		irq_int_controller <= ins_irq_ctrl;
		irq_timer <= ins_irq_timer;
		irq_software <= ins_irq_sw;
		@(negedge clk);
		pend = model_mip() & m_mie;
		irq = !ins_exc && m_mstatus[`MSTATUS_MIE_BIT] && (pend != '0);
		trap = ins_exc || irq;
		old = model_read(ins_csr_addr);
		check_word("ready_out", ready_out, 1);
		check_word("M_ena_csr", M_ena_csr, m_misa[`MISA_M_BIT]);
		check_word("F_ena_csr", F_ena_csr, m_misa[`MISA_F_BIT]);
		check_word("fpu_rm_csr", fpu_rm_csr, m_frm);
		check_word("exc_taken_csr", exc_taken_csr, ins_exc);
		check_word("trap_taken_csr", trap_taken_csr, trap);
		check_word("rd_wena_WB", rd_wena_WB, ins_rd_wena && !trap);
		check_word("rd_addr_WB", rd_addr_WB, ins_rd_addr);
		check_word("rd_data_WB", rd_data_WB, (ins_wb_src == SEL_CSR) ? old : ins_rd_data);
		check_word("trap_raddr_csr", trap_raddr_csr, m_mepc);
		if (trap)
			check_word("trap_addr_csr", trap_addr_csr, m_mtvec & ~32'h3);
		if (trap) begin
			m_mepc = ins_pc;
			m_mcause = ins_exc ? ins_cause : expected_irq_cause(pend);
			m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
			m_mstatus[`MSTATUS_MIE_BIT] = 1'b0;
		end else begin
			if (ins_ret) begin
				m_mstatus[`MSTATUS_MIE_BIT] = m_mstatus[`MSTATUS_MPIE_BIT];
				m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
			end else if (ins_csr_wena && ins_csr_op != CSR_NONE) begin
				case (ins_csr_op)
					CSR_RW:		nv = ins_csr_wdata;
					CSR_RS:		nv = old | ins_csr_wdata;
					default:	nv = old & ~ins_csr_wdata;
				endcase
				case (ins_csr_addr)
					CSR_MSTATUS:	m_mstatus = nv;
					CSR_MISA:		m_misa = (m_misa & ~MISA_MASK) | (nv & MISA_MASK);
					CSR_MIE:		m_mie = nv & `MIE_MASK;
					CSR_MTVEC:		m_mtvec = nv;
					CSR_MEPC:		m_mepc = nv;
					CSR_MCAUSE:		m_mcause = nv;
					CSR_FFLAGS:		m_fflags = nv[4:0];
					CSR_FRM:		m_frm = nv[2:0];
					CSR_FCSR: begin
						m_frm = nv[7:5];
						m_fflags = nv[4:0];
					end
					default:		;	// mip is read only
				endcase
			end
			m_fflags |= ins_flags;
		end
		@(posedge clk);
		valid_in <= 1'b0;
		ready_in <= !stall_after;
		wait_valid_out(1'b1);
	endtask

	task automatic csr_write(input csr_addr_t addr, input csr_op_e op, input word_t data);
		clear_fields();
		ins_csr_addr = addr;
		ins_csr_wena = 1'b1;
		ins_csr_op = op;
		ins_csr_wdata = data;
		issue();
	endtask

	task automatic csr_read(input csr_addr_t addr);
		clear_fields();
		ins_csr_addr = addr;
		ins_wb_src = SEL_CSR;
		issue();
	endtask

	initial begin
		word_t r;
		reset <= 1'b1;
		valid_in <= 1'b0;
		ready_in <= 1'b1;
		irq_ext <= '0;
		irq_int_controller <= 1'b0;
		irq_timer <= 1'b0;
		irq_software <= 1'b0;
		PC_MEM <= '0;
		rd_wena_MEM <= 1'b0;
		rd_addr_MEM <= '0;
		rd_data_MEM <= '0;
		csr_addr_MEM <= '0;
		csr_rena_MEM <= 1'b0;
		csr_wena_MEM <= 1'b0;
		csr_wdata_MEM <= '0;
		wb_src_MEM <= SEL_RES;
		csr_op_MEM <= CSR_NONE;
		fpu_flags_MEM <= '0;
		trap_ret_MEM <= 1'b0;
		exc_pend_MEM <= 1'b0;
		exc_cause_MEM <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_word("valid_out", valid_out, 0);
		check_word("trap_taken_csr", trap_taken_csr, 0);
		check_word("rd_wena_WB", rd_wena_WB, 0);
		check_word("fpu_rm_csr", fpu_rm_csr, 0);
		check_word("M_ena_csr", M_ena_csr, 1);
		check_word("F_ena_csr", F_ena_csr, 1);

		// plain writeback
		repeat (8) begin
			clear_fields();
			r = rand_word();
			ins_rd_wena = r[0];
			ins_rd_addr = reg_addr_t'(r >> 8);
			ins_rd_data = rand_word();
			issue();
		end

		// back-pressure, held instruction must not write or trap
		clear_fields();
		issue(1'b1);
		@(posedge clk);
		valid_in <= 1'b1;
		csr_addr_MEM <= CSR_MTVEC;
		csr_wena_MEM <= 1'b1;
		csr_op_MEM <= CSR_RW;
		csr_wdata_MEM <= rand_word();
		rd_wena_MEM <= 1'b1;
		exc_pend_MEM <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_word("valid_out", valid_out, 1);
			check_word("ready_out", ready_out, 0);
			check_word("rd_wena_WB", rd_wena_WB, 0);
			check_word("trap_taken_csr", trap_taken_csr, 0);
		end
		@(posedge clk);
		valid_in <= 1'b0;
		ready_in <= 1'b1;
		exc_pend_MEM <= 1'b0;
		wait_valid_out(1'b0);
		csr_read(CSR_MTVEC);

		// random csr traffic
		foreach (csr_list[k]) begin
			repeat (4) begin
				clear_fields();
				ins_csr_addr = csr_list[k];
				ins_wb_src = SEL_CSR;
				ins_csr_wena = 1'b1;
				ins_csr_op = csr_op_e'(2'(rand_word() % 3) + 2'd1);
				ins_csr_wdata = rand_word();
				if (csr_list[k] == CSR_MIP) begin
					r = rand_word();
					ins_irq_ext = r[31:16];
					ins_irq_ctrl = r[1];
					ins_irq_timer = r[2];
					ins_irq_sw = r[3];
				end
				issue();
			end
		end
		ins_irq_ext = '0;
		ins_irq_ctrl = 1'b0;
		ins_irq_timer = 1'b0;
		ins_irq_sw = 1'b0;
		csr_write(CSR_MISA, CSR_RC, 32'hFFFF_FFFF);
		csr_read(CSR_MISA);
		csr_write(CSR_MISA, CSR_RS, 32'hFFFF_FFFF);
		csr_read(CSR_MISA);

		// fflags accumulation
		repeat (5) begin
			clear_fields();
			ins_flags = fflags_t'(rand_word());
			issue();
		end
		csr_read(CSR_FFLAGS);
		csr_write(CSR_FFLAGS, CSR_RW, '0);
		clear_fields();
		ins_flags = 5'h01;
		issue();
		clear_fields();
		ins_flags = 5'h1e;
		ins_exc = 1'b1;
		ins_cause = 32'd2;
		issue();
		csr_read(CSR_FCSR);

		// exception with misaligned mtvec
		csr_write(CSR_MTVEC, CSR_RW, rand_word() | 32'h3);
		clear_fields();
		ins_exc = 1'b1;
		ins_cause = rand_word() & 32'h1F;
		ins_rd_wena = 1'b1;
		ins_csr_addr = CSR_MTVEC;
		ins_csr_wena = 1'b1;
		ins_csr_op = CSR_RW;
		issue();
		csr_read(CSR_MCAUSE);
		csr_read(CSR_MTVEC);

		// interrupts, one round per priority level
		csr_write(CSR_MIE, CSR_RW, 32'hFFFF_FFFF);
		csr_write(CSR_MSTATUS, CSR_RW, 32'h1 << `MSTATUS_MPIE_BIT);
		for (int round = 0; round < 4; round++) begin
			ins_irq_timer = 1'b1;
			ins_irq_sw = (round < 3);
			ins_irq_ctrl = (round < 2);
			ins_irq_ext = (round == 0) ? 16'h0220 : '0;
			csr_read(CSR_MCAUSE);		// MIE clear, must not trap
			clear_fields();
			ins_ret = 1'b1;
			issue();
			clear_fields();
			ins_rd_wena = 1'b1;
			issue();
		end
		ins_irq_ext = '0;
		ins_irq_ctrl = 1'b0;
		ins_irq_timer = 1'b0;
		ins_irq_sw = 1'b0;
		csr_read(CSR_MCAUSE);
		csr_read(CSR_MSTATUS);

		@(posedge clk);
		if (wb_stage_inst.props_inst.fail_count != 0) begin
			$display("Test failed");
			$fatal(1, "concurrent assertion failures");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`XLEN-1:0]	word_t;
	typedef logic [5:0]			reg_addr_t;		// 32+ are float registers
	typedef logic [11:0]		csr_addr_t;
	typedef logic [4:0]			fflags_t;
	typedef logic [2:0]			frm_t;
	typedef logic [31:0]		cause_t;		// bit 31 set for interrupts

	typedef enum logic [1:0] {
		CSR_NONE	= 2'd0,
		CSR_RW		= 2'd1,
		CSR_RS		= 2'd2,
		CSR_RC		= 2'd3
	} csr_op_e;

	typedef enum logic [2:0] {
		SEL_RES		= 3'd0,
		SEL_CSR		= 3'd1
	} wb_src_e;

	// machine mode
	localparam csr_addr_t CSR_MSTATUS	= 12'h300;
	localparam csr_addr_t CSR_MISA		= 12'h301;
	localparam csr_addr_t CSR_MIE		= 12'h304;
	localparam csr_addr_t CSR_MTVEC		= 12'h305;
	localparam csr_addr_t CSR_MEPC		= 12'h341;
	localparam csr_addr_t CSR_MCAUSE	= 12'h342;
	localparam csr_addr_t CSR_MIP		= 12'h344;

	// float unit, all views of fcsr
	localparam csr_addr_t CSR_FFLAGS	= 12'h001;
	localparam csr_addr_t CSR_FRM		= 12'h002;
	localparam csr_addr_t CSR_FCSR		= 12'h003;

	// interrupt cause codes
	localparam int CAUSE_IRQ_SOFTWARE	= 3;
	localparam int CAUSE_IRQ_TIMER		= 7;
	localparam int CAUSE_IRQ_CTRL		= 11;
	localparam int CAUSE_IRQ_EXT_BASE	= 16;	// platform line n at 16+n

endpackage

`default_nettype wire

/* src/csr_file.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module csr_file (
	input	wire logic						clk,
	input	wire logic						reset,
	input	wire logic						accept,
	input	wire cpu_pkg::csr_addr_t		csr_addr,
	input	wire cpu_pkg::csr_op_e			csr_op,
	input	wire logic						csr_rena,
	input	wire logic						csr_wena,
	input	wire cpu_pkg::word_t			csr_wdata,
	output	cpu_pkg::word_t					csr_rdata,
	input	wire cpu_pkg::fflags_t			fpu_flags,
	input	wire logic [`IRQ_EXT_LINES-1:0]	irq_ext,
	input	wire logic						irq_int_controller,
	input	wire logic						irq_timer,
	input	wire logic						irq_software,
	output	logic							M_ena,
	output	logic							F_ena,
	output	cpu_pkg::frm_t					fpu_rm,
	trap_csr_if.csr							trap
);

	import cpu_pkg::*;

	word_t		mstatus;
	word_t		misa;
	word_t		mie;
	word_t		mtvec;
	word_t		mepc;
	word_t		mcause;
	word_t		mip;
	fflags_t	fflags_q;
	frm_t		frm_q;

	word_t		csr_old;
	word_t		csr_new;
	logic		csr_we;
	logic		wr_fflags;
	logic		wr_frm;
	fflags_t	fflags_base;
	frm_t		frm_new;

	// pending lines, not writable
	assign mip = {irq_ext, 4'b0, irq_int_controller, 3'b0, irq_timer, 3'b0,
			irq_software, 3'b0};

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS:	csr_old = mstatus;
			CSR_MISA:		csr_old = misa;
			CSR_MIE:		csr_old = mie;
			CSR_MTVEC:		csr_old = mtvec;
			CSR_MEPC:		csr_old = mepc;
			CSR_MCAUSE:		csr_old = mcause;
			CSR_MIP:		csr_old = mip;
			CSR_FFLAGS:		csr_old = {27'b0, fflags_q};
			CSR_FRM:		csr_old = {29'b0, frm_q};
			CSR_FCSR:		csr_old = {24'b0, frm_q, fflags_q};
			default:		csr_old = '0;
		endcase
	end

	assign csr_rdata = csr_rena ? csr_old : '0;

	always_comb begin
		case (csr_op)
			CSR_RW:		csr_new = csr_wdata;
			CSR_RS:		csr_new = csr_old | csr_wdata;
			CSR_RC:		csr_new = csr_old & ~csr_wdata;
			default:	csr_new = csr_old;
		endcase
	end

	assign csr_we = accept && csr_wena && (csr_op != CSR_NONE) && !trap.trap_take;

	assign wr_fflags = csr_we && (csr_addr == CSR_FFLAGS || csr_addr == CSR_FCSR);
	assign wr_frm = csr_we && (csr_addr == CSR_FRM || csr_addr == CSR_FCSR);

	// flags from a csr write, then or in this instruction's flags
	assign fflags_base = wr_fflags ? csr_new[4:0] : fflags_q;
	assign frm_new = (csr_addr == CSR_FCSR) ? csr_new[7:5] : csr_new[2:0];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			mstatus		<= '0;
			misa		<= `MISA_RESET;
			mie			<= '0;
			mtvec		<= `MTVEC_RESET;
			mepc		<= '0;
			mcause		<= '0;
			fflags_q	<= '0;
			frm_q		<= '0;
		end else begin
			if (trap.trap_take) begin
				mepc	<= trap.trap_pc;
				mcause	<= trap.trap_cause;
				mstatus[`MSTATUS_MPIE_BIT]	<= mstatus[`MSTATUS_MIE_BIT];
				mstatus[`MSTATUS_MIE_BIT]	<= 1'b0;
			end else if (trap.mret_commit) begin
				mstatus[`MSTATUS_MIE_BIT]	<= mstatus[`MSTATUS_MPIE_BIT];
				mstatus[`MSTATUS_MPIE_BIT]	<= 1'b1;
			end else if (csr_we) begin
				case (csr_addr)
					CSR_MSTATUS:	mstatus <= csr_new;
					CSR_MISA:		misa <= (misa & ~`MISA_WMASK) | (csr_new & `MISA_WMASK);
					CSR_MIE:		mie <= csr_new & `MIE_MASK;
					CSR_MTVEC:		mtvec <= csr_new;
					CSR_MEPC:		mepc <= csr_new;
					CSR_MCAUSE:		mcause <= csr_new;
					default:		;	// mip and float views handled elsewhere
				endcase
			end

			if (accept && !trap.trap_take)
				fflags_q <= fflags_base | fpu_flags;

			if (wr_frm)
				frm_q <= frm_new;
		end
	end

	assign M_ena	= misa[`MISA_M_BIT];
	assign F_ena	= misa[`MISA_F_BIT];
	assign fpu_rm	= frm_q;

	assign trap.mie_global	= mstatus[`MSTATUS_MIE_BIT];
	assign trap.mie_mask	= mie;
	assign trap.mip_bits	= mip;
	assign trap.mtvec		= mtvec;
	assign trap.mepc		= mepc;

endmodule

`default_nettype wire

/* src/trap_csr_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface trap_csr_if;

	import cpu_pkg::*;

	// csr file side
	logic	mie_global;		// mstatus.MIE
	word_t	mie_mask;
	word_t	mip_bits;
	word_t	mtvec;
	word_t	mepc;

	// trap unit side
	logic	trap_take;
	cause_t	trap_cause;
	word_t	trap_pc;
	logic	mret_commit;

	modport csr (
		output	mie_global,
		output	mie_mask,
		output	mip_bits,
		output	mtvec,
		output	mepc,
		input	trap_take,
		input	trap_cause,
		input	trap_pc,
		input	mret_commit
	);

	modport trap (
		input	mie_global,
		input	mie_mask,
		input	mip_bits,
		input	mtvec,
		input	mepc,
		output	trap_take,
		output	trap_cause,
		output	trap_pc,
		output	mret_commit
	);

endinterface

`default_nettype wire

/* src/trap_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module trap_unit (
	input	wire logic				accept,
	input	wire logic				exc_pend,
	input	wire cpu_pkg::cause_t	exc_cause,
	input	wire logic				trap_ret,
	input	wire cpu_pkg::word_t	pc,
	output	logic					exc_taken,
	output	logic					trap_taken,
	output	cpu_pkg::word_t			trap_addr,
	output	cpu_pkg::word_t			trap_raddr,
	trap_csr_if.trap				trap
);

	import cpu_pkg::*;

	word_t		irq_pend;
	logic		irq_any;
	logic		irq_taken;
	logic [4:0]	irq_code;
	cause_t		irq_cause;

	assign irq_pend	= trap.mip_bits & trap.mie_mask;
	assign irq_any	= trap.mie_global && (irq_pend != '0);

	// later assignments win, so lowest priority comes first
	always_comb begin
		irq_code = '0;
		if (irq_pend[CAUSE_IRQ_TIMER])
			irq_code = 5'(CAUSE_IRQ_TIMER);
		if (irq_pend[CAUSE_IRQ_SOFTWARE])
			irq_code = 5'(CAUSE_IRQ_SOFTWARE);
		if (irq_pend[CAUSE_IRQ_CTRL])
			irq_code = 5'(CAUSE_IRQ_CTRL);
		for (int i = `IRQ_EXT_LINES - 1; i >= 0; i--) begin
			if (irq_pend[CAUSE_IRQ_EXT_BASE + i])
				irq_code = 5'(CAUSE_IRQ_EXT_BASE + i);	// lowest line wins
		end
	end

	assign irq_cause = {1'b1, 26'b0, irq_code};

	// exceptions from earlier stages beat interrupts
	assign exc_taken	= accept && exc_pend;
	assign irq_taken	= accept && !exc_pend && irq_any;
	assign trap_taken	= exc_taken || irq_taken;

	assign trap.trap_take	= trap_taken;
	assign trap.trap_cause	= exc_pend ? exc_cause : irq_cause;
	assign trap.trap_pc		= pc;
	assign trap.mret_commit	= accept && trap_ret && !trap_taken;

	// direct mode only
	assign trap_addr	= {trap.mtvec[`XLEN-1:2], 2'b00};
	assign trap_raddr	= trap.mepc;

endmodule

`default_nettype wire

/* src/wb_commit.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_commit (
	input	wire logic					clk,
	input	wire logic					reset,
	input	wire logic					valid_in,
	input	wire logic					ready_in,
	output	logic						ready_out,
	output	logic						valid_out,
	output	logic						accept,
	input	wire logic					trap_taken,
	input	wire cpu_pkg::wb_src_e		wb_src,
	input	wire logic					rd_wena,
	input	wire cpu_pkg::reg_addr_t	rd_addr,
	input	wire cpu_pkg::word_t		rd_data,
	input	wire cpu_pkg::word_t		csr_rdata,
	output	logic						rd_wena_WB,
	output	cpu_pkg::reg_addr_t			rd_addr_WB,
	output	cpu_pkg::word_t				rd_data_WB
);

	import cpu_pkg::*;

	// no buffering here, so stall straight through
	assign ready_out	= ready_in;
	assign accept		= valid_in && ready_in;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			valid_out <= 1'b0;
		else if (accept)
			valid_out <= 1'b1;
		else if (ready_in)
			valid_out <= 1'b0;	// consumed, nothing new
	end

	// trapping instruction must not retire its result
	assign rd_wena_WB	= accept && rd_wena && !trap_taken;
	assign rd_addr_WB	= rd_addr;
	assign rd_data_WB	= (wb_src == SEL_CSR) ? csr_rdata : rd_data;

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module wb_stage (
	input	wire logic						clk,
	input	wire logic						reset,

	input	wire logic						valid_in,
	output	logic							ready_out,
	output	logic							valid_out,
	input	wire logic						ready_in,

	input	wire logic [`IRQ_EXT_LINES-1:0]	irq_ext,
	input	wire logic						irq_int_controller,
	input	wire logic						irq_timer,
	input	wire logic						irq_software,

	output	logic							M_ena_csr,
	output	logic							F_ena_csr,
	output	cpu_pkg::frm_t					fpu_rm_csr,
	output	logic							exc_taken_csr,
	output	logic							trap_taken_csr,
	output	cpu_pkg::word_t					trap_addr_csr,
	output	cpu_pkg::word_t					trap_raddr_csr,

	input	wire cpu_pkg::word_t			PC_MEM,
	input	wire logic						rd_wena_MEM,
	input	wire cpu_pkg::reg_addr_t		rd_addr_MEM,
	input	wire cpu_pkg::word_t			rd_data_MEM,
	input	wire cpu_pkg::csr_addr_t		csr_addr_MEM,
	input	wire logic						csr_rena_MEM,
	input	wire logic						csr_wena_MEM,
	input	wire cpu_pkg::word_t			csr_wdata_MEM,
	input	wire cpu_pkg::wb_src_e			wb_src_MEM,
	input	wire cpu_pkg::csr_op_e			csr_op_MEM,
	input	wire cpu_pkg::fflags_t			fpu_flags_MEM,
	input	wire logic						trap_ret_MEM,
	input	wire logic						exc_pend_MEM,
	input	wire cpu_pkg::cause_t			exc_cause_MEM,

	output	logic							rd_wena_WB,
	output	cpu_pkg::reg_addr_t				rd_addr_WB,
	output	cpu_pkg::word_t					rd_data_WB
);

	import cpu_pkg::*;

	logic	accept;
	word_t	csr_rdata;

	trap_csr_if trap_bus ();

	csr_file csr_file_inst (
		.clk				(clk),
		.reset				(reset),
		.accept				(accept),
		.csr_addr			(csr_addr_MEM),
		.csr_op				(csr_op_MEM),
		.csr_rena			(csr_rena_MEM),
		.csr_wena			(csr_wena_MEM),
		.csr_wdata			(csr_wdata_MEM),
		.csr_rdata			(csr_rdata),
		.fpu_flags			(fpu_flags_MEM),
		.irq_ext			(irq_ext),
		.irq_int_controller	(irq_int_controller),
		.irq_timer			(irq_timer),
		.irq_software		(irq_software),
		.M_ena				(M_ena_csr),
		.F_ena				(F_ena_csr),
		.fpu_rm				(fpu_rm_csr),
		.trap				(trap_bus.csr)
	);

	trap_unit trap_unit_inst (
		.accept		(accept),
		.exc_pend	(exc_pend_MEM),
		.exc_cause	(exc_cause_MEM),
		.trap_ret	(trap_ret_MEM),
		.pc			(PC_MEM),
		.exc_taken	(exc_taken_csr),
		.trap_taken	(trap_taken_csr),
		.trap_addr	(trap_addr_csr),
		.trap_raddr	(trap_raddr_csr),
		.trap		(trap_bus.trap)
	);

	wb_commit wb_commit_inst (
		.clk		(clk),
		.reset		(reset),
		.valid_in	(valid_in),
		.ready_in	(ready_in),
		.ready_out	(ready_out),
		.valid_out	(valid_out),
		.accept		(accept),
		.trap_taken	(trap_taken_csr),
		.wb_src		(wb_src_MEM),
		.rd_wena	(rd_wena_MEM),
		.rd_addr	(rd_addr_MEM),
		.rd_data	(rd_data_MEM),
		.csr_rdata	(csr_rdata),
		.rd_wena_WB	(rd_wena_WB),
		.rd_addr_WB	(rd_addr_WB),
		.rd_data_WB	(rd_data_WB)
	);

endmodule

`default_nettype wire
